/* hdl/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Core sizing
`define CPU_IMEM_DEPTH 32 // Instruction words
`define CPU_NUM_REGS 32 // General registers
`define CPU_NUM_PORTS 4 // Output ports
`define CPU_LINK_REG 31 // Return address register for jal

// APB address map, byte addresses
`define APB_IMEM_BASE 12'h000 // Instruction words at 0x000..0x07C
`define APB_CTRL_ADDR 12'h100 // Bit 0 starts the core
`define APB_STATUS_ADDR 12'h104 // Busy, halted, PC
`define APB_PORT_BASE 12'h110 // Ports at 0x110..0x11C

`endif

/* hdl/isa_pkg.sv */
`include "cpu_defs.svh"

package isa_pkg;

	typedef logic [31:0] word_t; // Instruction or data word
	typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t; // Register number
	typedef logic [15:0] imm_t; // Immediate field
	typedef logic [$clog2(`CPU_IMEM_DEPTH)-1:0] imem_addr_t; // Instruction index

	typedef enum logic [5:0] {
		NOP = 6'b000000,
		ADD = 6'b000001,
		ADDI = 6'b000010,
		SUB = 6'b000011,
		SUBI = 6'b000100,
		MOV = 6'b010010,
		LI = 6'b010100,
		JUMP = 6'b011101,
		JAL = 6'b011110,
		JR = 6'b011111,
		OUT = 6'b100001,
		HALT = 6'b111111
	} opcode_t;

	// R format, rd sits on the top of the immediate
	typedef struct packed {
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		logic [10:0] pad; // Unused low bits
	} r_fields_t;

	typedef struct packed {
		reg_idx_t rs;
		reg_idx_t rt;
		imm_t imm;
	} i_fields_t;

	typedef union packed {
		r_fields_t r;
		i_fields_t i;
		logic [25:0] target; // Jump format
	} operands_t;

	typedef struct packed {
		opcode_t opcode;
		operands_t op;
	} decoded_t;

	typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_EXECUTE, ST_HALTED} core_state_t;

endpackage

/* hdl/apb_pkg.sv */
package apb_pkg;

	typedef logic [11:0] apb_addr_t; // Byte address

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		apb_addr_t paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready; // Tied high, no wait states
		logic pslverr;
	} apb_rsp_t;

endpackage

/* hdl/instruction_memory.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module instruction_memory (
	input logic clock,
	input logic rst,
	input logic we, // Host write strobe
	input isa_pkg::imem_addr_t waddr,
	input isa_pkg::word_t wdata,
	input isa_pkg::imem_addr_t raddr, // Core fetch address
	input isa_pkg::imem_addr_t haddr, // Host readback address
	output isa_pkg::word_t instr,
	output isa_pkg::word_t host_rdata
);

	localparam int DEPTH = `CPU_IMEM_DEPTH;

	isa_pkg::word_t mem [DEPTH]; // Program store

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0; // All nop
			end
		end else if (we) begin
			mem[waddr] <= wdata;
		end
	end

	assign instr = mem[raddr]; // Fetch port
	assign host_rdata = mem[haddr]; // APB readback port

	// Host decode must keep writes inside the store
	a_waddr_in_range: assert property (
		@(posedge clock) disable iff (rst)
		we |-> (int'(waddr) < DEPTH)
	) else $error("instruction memory write outside depth");

endmodule

/* hdl/program_counter.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module program_counter (
	input logic clock,
	input logic rst,
	input logic clear, // Start of a run
	input logic inc,
	input logic load, // Jump, jal, jr
	input isa_pkg::imem_addr_t target,
	output isa_pkg::imem_addr_t pc
);

	localparam isa_pkg::imem_addr_t LAST = isa_pkg::imem_addr_t'(`CPU_IMEM_DEPTH - 1);

	isa_pkg::imem_addr_t pc_plus1;

	assign pc_plus1 = (pc == LAST) ? '0 : pc + 1'b1; // Wrap at depth

	always_ff @(posedge clock) begin
		if (rst || clear) begin
			pc <= '0;
		end else if (load) begin
			pc <= target; // Low bits only
		end else if (inc) begin
			pc <= pc_plus1;
		end
	end

	// The FSM never asks for both
	a_inc_load_excl: assert property (
		@(posedge clock) disable iff (rst)
		!(inc && load)
	) else $error("pc inc and load together");

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module register_file (
	input logic clock,
	input logic rst,
	input logic we,
	input isa_pkg::reg_idx_t waddr,
	input isa_pkg::word_t wdata,
	input isa_pkg::reg_idx_t raddr_a, // rs
	input isa_pkg::reg_idx_t raddr_b, // rt
	output isa_pkg::word_t rdata_a,
	output isa_pkg::word_t rdata_b
);

	localparam int NREGS = `CPU_NUM_REGS;

	isa_pkg::word_t regs [NREGS];

	// r0 is an ordinary register here
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// Old value seen in the write cycle
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

endmodule

/* hdl/execute_unit.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module execute_unit (
	input logic clock,
	input logic rst,
	input logic ir_load, // Fetch cycle
	input isa_pkg::word_t instr,
	input isa_pkg::imem_addr_t pc, // Still at the executing word
	input isa_pkg::word_t rdata_a,
	input isa_pkg::word_t rdata_b,
	output isa_pkg::decoded_t dec,
	output isa_pkg::reg_idx_t raddr_a,
	output isa_pkg::reg_idx_t raddr_b,
	output isa_pkg::reg_idx_t waddr,
	output isa_pkg::word_t wdata,
	output isa_pkg::imem_addr_t target,
	output logic [1:0] port_idx,
	output isa_pkg::word_t port_value
);

	isa_pkg::decoded_t ir; // Instruction register
	isa_pkg::word_t imm_sext;

	always_ff @(posedge clock) begin
		if (rst) begin
			ir <= '0; // Nop
		end else if (ir_load) begin
			ir <= isa_pkg::decoded_t'(instr);
		end
	end

	assign dec = ir;
	assign raddr_a = ir.op.i.rs;
	assign raddr_b = ir.op.i.rt;
	assign imm_sext = {{16{ir.op.i.imm[15]}}, ir.op.i.imm}; // Sign extend

	always_comb begin
		waddr = ir.op.i.rt; // I format default
		wdata = rdata_a;
		target = isa_pkg::imem_addr_t'(ir.op.target);
		case (ir.opcode)
			isa_pkg::ADD: begin
				waddr = ir.op.r.rd;
				wdata = rdata_a + rdata_b;
			end
			isa_pkg::SUB: begin
				waddr = ir.op.r.rd;
				wdata = rdata_a - rdata_b; // Wraps
			end
			isa_pkg::ADDI: wdata = rdata_a + imm_sext;
			isa_pkg::SUBI: wdata = rdata_a - imm_sext;
			isa_pkg::LI: wdata = imm_sext;
			isa_pkg::JAL: begin
				waddr = isa_pkg::reg_idx_t'(`CPU_LINK_REG);
				wdata = isa_pkg::word_t'(pc) + 32'd1; // Return address
			end
			isa_pkg::JR: target = isa_pkg::imem_addr_t'(rdata_b); // Low bits of rt
			default: ; // Mov keeps the defaults
		endcase
	end

	assign port_idx = ir.op.i.imm[1:0];
	assign port_value = rdata_b; // out sends rt

endmodule

/* hdl/core_control.sv */
`timescale 1ns/1ps

module core_control (
	input logic clock,
	input logic rst,
	input logic start, // One-cycle pulse from host
	input isa_pkg::decoded_t dec,
	output isa_pkg::core_state_t state,
	output logic ir_load,
	output logic pc_clear,
	output logic pc_inc,
	output logic pc_load,
	output logic rf_we,
	output logic port_we
);

	isa_pkg::core_state_t state_next;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= isa_pkg::ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		ir_load = 1'b0;
		pc_clear = 1'b0;
		pc_inc = 1'b0;
		pc_load = 1'b0;
		rf_we = 1'b0;
		port_we = 1'b0;
		case (state)
			isa_pkg::ST_FETCH: begin
				ir_load = 1'b1; // Latch mem[pc]
				state_next = isa_pkg::ST_EXECUTE;
			end
			isa_pkg::ST_EXECUTE: begin
				state_next = isa_pkg::ST_FETCH;
				case (dec.opcode)
					isa_pkg::ADD, isa_pkg::SUB, isa_pkg::ADDI, isa_pkg::SUBI,
					isa_pkg::MOV, isa_pkg::LI: begin
						rf_we = 1'b1;
						pc_inc = 1'b1;
					end
					isa_pkg::JAL: begin
						rf_we = 1'b1; // Link
						pc_load = 1'b1;
					end
					isa_pkg::JUMP, isa_pkg::JR: pc_load = 1'b1;
					isa_pkg::OUT: begin
						port_we = 1'b1;
						pc_inc = 1'b1;
					end
					isa_pkg::HALT: state_next = isa_pkg::ST_HALTED; // PC stays on halt
					default: pc_inc = 1'b1; // Nop and unknown
				endcase
			end
			default: begin // Idle or halted
				if (start) begin
					pc_clear = 1'b1; // Run from address 0
					state_next = isa_pkg::ST_FETCH;
				end
			end
		endcase
	end

	// Side effects only land in execute
	a_we_in_execute: assert property (
		@(posedge clock) disable iff (rst)
		(rf_we || port_we) |-> (state == isa_pkg::ST_EXECUTE)
	) else $error("register or port write outside execute");

	a_ir_in_fetch: assert property (
		@(posedge clock) disable iff (rst)
		ir_load |-> (state == isa_pkg::ST_FETCH)
	) else $error("ir_load outside fetch");

endmodule

/* hdl/host_interface.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module host_interface (
	input logic clock,
	input logic rst,
	input apb_pkg::apb_req_t req,
	input isa_pkg::core_state_t state,
	input isa_pkg::imem_addr_t pc,
	input isa_pkg::word_t imem_rdata,
	input logic port_we, // From FSM in execute
	input logic [1:0] port_idx,
	input isa_pkg::word_t port_value,
	output apb_pkg::apb_rsp_t rsp,
	output logic imem_we,
	output isa_pkg::imem_addr_t imem_waddr,
	output isa_pkg::word_t imem_wdata,
	output isa_pkg::imem_addr_t imem_haddr,
	output logic start
);

	localparam apb_pkg::apb_addr_t IMEM_SPAN = apb_pkg::apb_addr_t'(`CPU_IMEM_DEPTH * 4);
	localparam apb_pkg::apb_addr_t PORT_SPAN = apb_pkg::apb_addr_t'(`CPU_NUM_PORTS * 4);

	isa_pkg::word_t ports [`CPU_NUM_PORTS]; // Output port registers
	apb_pkg::apb_addr_t imem_off, port_off;
	logic access, busy, halted;
	logic hit_imem, hit_ctrl, hit_status, hit_port;
	isa_pkg::word_t status_word;

	assign access = req.psel && req.penable; // Access phase
	assign busy = (state == isa_pkg::ST_FETCH) || (state == isa_pkg::ST_EXECUTE);
	assign halted = (state == isa_pkg::ST_HALTED);

	assign imem_off = req.paddr - `APB_IMEM_BASE;
	assign port_off = req.paddr - `APB_PORT_BASE;
	assign hit_imem = imem_off < IMEM_SPAN;
	assign hit_ctrl = req.paddr == `APB_CTRL_ADDR;
	assign hit_status = req.paddr == `APB_STATUS_ADDR;
	assign hit_port = port_off < PORT_SPAN;

	// Host side of the instruction store
	assign imem_haddr = isa_pkg::imem_addr_t'(imem_off >> 2);
	assign imem_waddr = imem_haddr;
	assign imem_wdata = req.pwdata;
	assign imem_we = access && req.pwrite && hit_imem && !busy;
	assign start = access && req.pwrite && hit_ctrl && !busy && req.pwdata[0];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NUM_PORTS; i++) begin
				ports[i] <= '0;
			end
		end else if (port_we) begin
			ports[port_idx] <= port_value; // out instruction
		end
	end

	always_comb begin
		status_word = '0;
		status_word[0] = busy;
		status_word[1] = halted;
		status_word[8 +: $bits(pc)] = pc;
	end

	always_comb begin
		rsp.pready = 1'b1; // Zero wait states
		rsp.prdata = '0;
		if (hit_imem) begin
			rsp.prdata = imem_rdata;
		end else if (hit_status) begin
			rsp.prdata = status_word;
		end else if (hit_port) begin
			rsp.prdata = ports[port_off[3:2]];
		end
		// Unmapped, busy writes, writes to read-only ports
		rsp.pslverr = access && (!(hit_imem || hit_ctrl || hit_status || hit_port)
			|| (req.pwrite && busy && (hit_imem || hit_ctrl))
			|| (req.pwrite && hit_port));
	end

	a_err_in_access: assert property (
		@(posedge clock) disable iff (rst)
		rsp.pslverr |-> (req.psel && req.penable)
	) else $error("pslverr outside access phase");

endmodule

/* hdl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
	input logic clock,
	input logic rst,
	input apb_pkg::apb_req_t apb_req,
	output apb_pkg::apb_rsp_t apb_rsp
);

	isa_pkg::core_state_t state;
	isa_pkg::decoded_t dec;
	isa_pkg::imem_addr_t pc, target, imem_waddr, imem_haddr;
	isa_pkg::word_t instr, imem_wdata, imem_rdata, rdata_a, rdata_b, wdata, port_value;
	isa_pkg::reg_idx_t raddr_a, raddr_b, waddr;
	logic [1:0] port_idx;
	logic imem_we, start, ir_load, pc_clear, pc_inc, pc_load, rf_we, port_we;

	host_interface i_host_interface (
		.clock, .rst, .req(apb_req), .state, .pc, .imem_rdata, .port_we, .port_idx,
		.port_value, .rsp(apb_rsp), .imem_we, .imem_waddr, .imem_wdata, .imem_haddr, .start
	);

	instruction_memory i_instruction_memory (
		.clock, .rst, .we(imem_we), .waddr(imem_waddr), .wdata(imem_wdata),
		.raddr(pc), .haddr(imem_haddr), .instr, .host_rdata(imem_rdata)
	);

	core_control i_core_control (
		.clock, .rst, .start, .dec, .state, .ir_load, .pc_clear, .pc_inc, .pc_load,
		.rf_we, .port_we
	);

	program_counter i_program_counter (
		.clock, .rst, .clear(pc_clear), .inc(pc_inc), .load(pc_load), .target, .pc
	);

	execute_unit i_execute_unit (
		.clock, .rst, .ir_load, .instr, .pc, .rdata_a, .rdata_b, .dec, .raddr_a, .raddr_b,
		.waddr, .wdata, .target, .port_idx, .port_value
	);

	register_file i_register_file (
		.clock, .rst, .we(rf_we), .waddr, .wdata, .raddr_a, .raddr_b, .rdata_a, .rdata_b
	);

endmodule

/* tb/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb;

	localparam int CLK_PERIOD = 40;
	localparam int RST_CYCLES = 10;
	localparam int PROG_WORDS = 12; // Longest program in the table
	localparam int NUM_ENTRIES = 4;
	localparam int NUM_TESTS = NUM_ENTRIES + 2; // Table plus readback and error tests
	localparam int LOAD_WRITES = `CPU_IMEM_DEPTH;
	localparam int POLL_CYCLES = 200;
	localparam int CYCLE_LIMIT = NUM_TESTS * (LOAD_WRITES * 2 + 2 * 64 + POLL_CYCLES) * 2;

	// Opcodes from the ISA table
	localparam logic [5:0] OP_ADD = 6'b000001;
	localparam logic [5:0] OP_ADDI = 6'b000010;
	localparam logic [5:0] OP_SUB = 6'b000011;
	localparam logic [5:0] OP_SUBI = 6'b000100;
	localparam logic [5:0] OP_MOV = 6'b010010;
	localparam logic [5:0] OP_LI = 6'b010100;
	localparam logic [5:0] OP_JUMP = 6'b011101;
	localparam logic [5:0] OP_JAL = 6'b011110;
	localparam logic [5:0] OP_JR = 6'b011111;
	localparam logic [5:0] OP_OUT = 6'b100001;
	localparam logic [5:0] OP_HALT = 6'b111111;

	logic clock;
	logic rst;
	apb_pkg::apb_req_t apb_req;
	apb_pkg::apb_rsp_t apb_rsp;

	isa_pkg::word_t prog [NUM_ENTRIES][PROG_WORDS]; // Program words per entry
	isa_pkg::word_t exp_port [NUM_ENTRIES][`CPU_NUM_PORTS];
	logic [4:0] exp_halt_pc [NUM_ENTRIES];
	string entry_name [NUM_ENTRIES];

	integer seed;
	int cycles = 0;
	int test_errors;
	int tests_passed;
	int tests_failed;

	cpu_top i_cpu_top (.clock, .rst, .apb_req, .apb_rsp);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// Run limit
	always @(posedge clock) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation FAILED");
			$finish;
		end
	end

	function automatic isa_pkg::word_t encode_imm(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic isa_pkg::word_t encode_reg(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {op, rs, rt, rd, 11'b0}; // rd on top of the immediate
	endfunction

	function automatic isa_pkg::word_t encode_jump(input logic [5:0] op, input logic [25:0] tgt);
		return {op, tgt};
	endfunction

	function automatic isa_pkg::word_t sign_extend(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic isa_pkg::word_t fill_word(input int idx);
		return (32'h9e37_79b9 * (idx + 1)) ^ 32'h5a5a_a5a5; // Differs per address
	endfunction

	task automatic compare_word(input string name, input isa_pkg::word_t expected,
		input isa_pkg::word_t actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected %h, got %h", name, expected, actual);
			test_errors++;
		end
	endtask

	// One APB transfer, setup then access, then idle
	task automatic apb_transfer(input logic write, input apb_pkg::apb_addr_t addr,
		input isa_pkg::word_t wdata, output isa_pkg::word_t rdata, output logic err);
		@(negedge clock);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = write;
		apb_req.paddr = addr;
		apb_req.pwdata = wdata;
		@(negedge clock);
		apb_req.penable = 1'b1;
		#(CLK_PERIOD / 4); // Mid access phase
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		if (apb_rsp.pready !== 1'b1) begin
			$display("FAIL pready at %h: expected 1, got %h", addr, apb_rsp.pready);
			test_errors++;
		end
		@(negedge clock);
		apb_req = '0;
	endtask

	task automatic write_word(input apb_pkg::apb_addr_t addr, input isa_pkg::word_t data,
		input logic exp_err);
		isa_pkg::word_t rdata;
		logic err;
		apb_transfer(1'b1, addr, data, rdata, err);
		if (err !== exp_err) begin
			$display("FAIL pslverr at %h: expected %h, got %h", addr, exp_err, err);
			test_errors++;
		end
	endtask

	task automatic read_word(input apb_pkg::apb_addr_t addr, output isa_pkg::word_t data,
		input logic exp_err);
		logic err;
		apb_transfer(1'b0, addr, 32'h0, data, err);
		if (err !== exp_err) begin
			$display("FAIL pslverr at %h: expected %h, got %h", addr, exp_err, err);
			test_errors++;
		end
	endtask

	task automatic reset_dut();
		@(negedge clock);
		rst = 1'b1;
		repeat (RST_CYCLES) @(negedge clock);
		rst = 1'b0;
	endtask

	// Bounded by the cycle limit
	task automatic wait_halted(output isa_pkg::word_t status);
		status = '0;
		while (status[1] !== 1'b1) begin
			read_word(`APB_STATUS_ADDR, status, 1'b0);
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d mismatches", name, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic run_and_check(input int e, input string run_name);
		isa_pkg::word_t status;
		isa_pkg::word_t value;
		write_word(`APB_CTRL_ADDR, 32'h1, 1'b0); // Start
		read_word(`APB_STATUS_ADDR, status, 1'b0);
		compare_word({run_name, " busy"}, 32'h1, {31'b0, status[0]});
		wait_halted(status);
		compare_word({run_name, " status"}, {19'b0, exp_halt_pc[e], 8'h02}, status);
		for (int p = 0; p < `CPU_NUM_PORTS; p++) begin
			read_word(`APB_PORT_BASE + apb_pkg::apb_addr_t'(4 * p), value, 1'b0);
			compare_word($sformatf("%s port%0d", run_name, p), exp_port[e][p], value);
		end
	endtask

	task automatic build_table();
		isa_pkg::word_t rnd;
		logic [15:0] imm_a, imm_b, imm_c, imm_d;
		for (int e = 0; e < NUM_ENTRIES; e++) begin
			for (int w = 0; w < PROG_WORDS; w++) begin
				prog[e][w] = '0; // Nop fill
			end
		end
		// ALU ops, negative immediate, wrapping subtract
		entry_name[0] = "arith";
		prog[0][0] = encode_imm(OP_LI, 5'd0, 5'd1, 16'd100);
		prog[0][1] = encode_imm(OP_LI, 5'd0, 5'd2, 16'hfff9); // -7
		prog[0][2] = encode_imm(OP_ADDI, 5'd1, 5'd3, 16'd25);
		prog[0][3] = encode_imm(OP_SUBI, 5'd2, 5'd4, 16'd3);
		prog[0][4] = encode_reg(OP_ADD, 5'd1, 5'd2, 5'd5);
		prog[0][5] = encode_reg(OP_SUB, 5'd1, 5'd3, 5'd6); // Goes negative
		prog[0][6] = encode_imm(OP_MOV, 5'd6, 5'd7, 16'd0);
		prog[0][7] = encode_imm(OP_OUT, 5'd0, 5'd4, 16'd0);
		prog[0][8] = encode_imm(OP_OUT, 5'd0, 5'd5, 16'd1);
		prog[0][9] = encode_imm(OP_OUT, 5'd0, 5'd7, 16'd2);
		prog[0][10] = encode_imm(OP_OUT, 5'd0, 5'd2, 16'd3);
		prog[0][11] = encode_jump(OP_HALT, 26'd0);
		exp_port[0][0] = sign_extend(16'hfff9) - 32'd3;
		exp_port[0][1] = 32'd100 + sign_extend(16'hfff9);
		exp_port[0][2] = 32'd100 - (32'd100 + 32'd25);
		exp_port[0][3] = sign_extend(16'hfff9);
		exp_halt_pc[0] = 5'd11;
		// Jump over dead words, subroutine called twice
		entry_name[1] = "control";
		prog[1][0] = encode_jump(OP_JUMP, 26'd3);
		prog[1][1] = encode_imm(OP_LI, 5'd0, 5'd5, 16'd77); // Never runs
		prog[1][2] = encode_jump(OP_HALT, 26'd0); // Never runs
		prog[1][3] = encode_imm(OP_LI, 5'd0, 5'd1, 16'd0);
		prog[1][4] = encode_jump(OP_JAL, 26'd10);
		prog[1][5] = encode_jump(OP_JAL, 26'd10);
		prog[1][6] = encode_imm(OP_OUT, 5'd0, 5'd1, 16'd0);
		prog[1][7] = encode_imm(OP_OUT, 5'd0, 5'd31, 16'd1);
		prog[1][8] = encode_imm(OP_OUT, 5'd0, 5'd5, 16'd2);
		prog[1][9] = encode_jump(OP_HALT, 26'd0);
		prog[1][10] = encode_imm(OP_ADDI, 5'd1, 5'd1, 16'd5); // Subroutine
		prog[1][11] = encode_imm(OP_JR, 5'd0, 5'd31, 16'd0);
		exp_port[1][0] = 32'd10; // Two calls
		exp_port[1][1] = 32'd6; // Link from the second jal
		exp_port[1][2] = 32'd0;
		exp_port[1][3] = 32'd0;
		exp_halt_pc[1] = 5'd9;
		// Random li and add operands
		for (int e = 2; e < NUM_ENTRIES; e++) begin
			entry_name[e] = $sformatf("random%0d", e - 1);
			rnd = $random(seed);
			imm_a = rnd[15:0];
			imm_b = rnd[31:16];
			rnd = $random(seed);
			imm_c = rnd[15:0];
			imm_d = rnd[31:16];
			prog[e][0] = encode_imm(OP_LI, 5'd0, 5'd1, imm_a);
			prog[e][1] = encode_imm(OP_LI, 5'd0, 5'd2, imm_b);
			prog[e][2] = encode_reg(OP_ADD, 5'd1, 5'd2, 5'd3);
			prog[e][3] = encode_imm(OP_OUT, 5'd0, 5'd3, 16'd0);
			prog[e][4] = encode_imm(OP_LI, 5'd0, 5'd4, imm_c);
			prog[e][5] = encode_imm(OP_LI, 5'd0, 5'd5, imm_d);
			prog[e][6] = encode_reg(OP_ADD, 5'd4, 5'd5, 5'd6);
			prog[e][7] = encode_imm(OP_OUT, 5'd0, 5'd6, 16'd1);
			prog[e][8] = encode_imm(OP_OUT, 5'd0, 5'd1, 16'd2);
			prog[e][9] = encode_imm(OP_OUT, 5'd0, 5'd5, 16'd3);
			prog[e][10] = encode_jump(OP_HALT, 26'd0);
			exp_port[e][0] = sign_extend(imm_a) + sign_extend(imm_b); // Mod 2^32
			exp_port[e][1] = sign_extend(imm_c) + sign_extend(imm_d);
			exp_port[e][2] = sign_extend(imm_a);
			exp_port[e][3] = sign_extend(imm_d);
			exp_halt_pc[e] = 5'd10;
		end
	endtask

	initial begin
		isa_pkg::word_t value;
		isa_pkg::word_t status;
		rst = 1'b1;
		apb_req = '0;
		seed = 32'heb5b;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		build_table();

		// Readback of every word, idle status
		reset_dut();
		read_word(`APB_STATUS_ADDR, value, 1'b0);
		compare_word("status after reset", 32'h0, value);
		for (int i = 0; i < `CPU_IMEM_DEPTH; i++) begin
			write_word(`APB_IMEM_BASE + apb_pkg::apb_addr_t'(4 * i), fill_word(i), 1'b0);
		end
		for (int i = 0; i < `CPU_IMEM_DEPTH; i++) begin
			read_word(`APB_IMEM_BASE + apb_pkg::apb_addr_t'(4 * i), value, 1'b0);
			compare_word($sformatf("imem[%0d]", i), fill_word(i), value);
		end
		finish_test("readback");

		for (int e = 0; e < NUM_ENTRIES; e++) begin
			reset_dut(); // Clean registers and ports
			for (int w = 0; w < PROG_WORDS; w++) begin
				write_word(`APB_IMEM_BASE + apb_pkg::apb_addr_t'(4 * w), prog[e][w], 1'b0);
			end
			run_and_check(e, "run");
			run_and_check(e, "rerun"); // Restart from halted
			finish_test(entry_name[e]);
		end

		// Error responses
		reset_dut();
		read_word(12'h200, value, 1'b1); // Unmapped
		write_word(`APB_PORT_BASE + 12'h004, 32'h1234, 1'b1); // Read-only port
		read_word(`APB_PORT_BASE + 12'h004, value, 1'b0);
		compare_word("port1", 32'h0, value);
		write_word(`APB_IMEM_BASE + 12'h02c, encode_jump(OP_HALT, 26'd0), 1'b0); // Halt at 11
		write_word(`APB_CTRL_ADDR, 32'h1, 1'b0);
		write_word(`APB_IMEM_BASE + 12'h02c, 32'hdead_beef, 1'b1); // Busy, dropped
		write_word(`APB_CTRL_ADDR, 32'h1, 1'b1);
		wait_halted(status);
		compare_word("status", {19'b0, 5'd11, 8'h02}, status);
		read_word(`APB_IMEM_BASE + 12'h02c, value, 1'b0);
		compare_word("imem[11]", encode_jump(OP_HALT, 26'd0), value);
		finish_test("errors");

		$display("tests run %0d, passed %0d, failed %0d",
			tests_passed + tests_failed, tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* all.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/apb_pkg.sv
hdl/instruction_memory.sv
hdl/program_counter.sv
hdl/register_file.sv
hdl/execute_unit.sv
hdl/core_control.sv
hdl/host_interface.sv
hdl/cpu_top.sv
tb/cpu_tb.sv

/* Makefile */
TOP = cpu_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
